/* source/dct_num_pkg.sv */
// numeric types, cosine table and rounding helpers shared by the dct datapath and its testbench
package dct_num_pkg;

  // ****************************************
  // sample and arithmetic widths
  // ****************************************
  typedef logic signed [15:0] sample_t;  // pixel or coefficient value
  typedef logic signed [15:0] coef_t;    // one cosine weight
  typedef logic signed [31:0] acc_t;     // sum of eight products

  localparam int DCT_N           = 8;   // points per 1-d pass
  localparam int COEF_TABLE_FRAC = 14;  // fraction bits of the stored table

  localparam acc_t SAMPLE_MAX = 32767;   // upper clip for a sample
  localparam acc_t SAMPLE_MIN = -32768;  // lower clip for a sample

  // ****************************************
  // cosine table, entry [k][n] = 2^14 * c(k)/2 * cos((2n+1)k*pi/16)
  // ****************************************
  localparam coef_t coef_table [DCT_N][DCT_N] = '{
    '{ 5793,  5793,  5793,  5793,  5793,  5793,  5793,  5793},  // k=0, dc
    '{ 8035,  6811,  4551,  1598, -1598, -4551, -6811, -8035},  // k=1
    '{ 7568,  3135, -3135, -7568, -7568, -3135,  3135,  7568},  // k=2
    '{ 6811, -1598, -8035, -4551,  4551,  8035,  1598, -6811},  // k=3
    '{ 5793, -5793, -5793,  5793,  5793, -5793, -5793,  5793},  // k=4
    '{ 4551, -8035,  1598,  6811, -6811, -1598,  8035, -4551},  // k=5
    '{ 3135, -7568,  7568, -3135, -3135,  7568, -7568,  3135},  // k=6
    '{ 1598, -4551,  6811, -8035,  8035, -6811,  4551, -1598}   // k=7
  };

  // table entry k,n requantized to frac fraction bits
  // rounding is half away from zero, so +/- pairs stay exact negatives
  function automatic coef_t scaled_coef(input int k, input int n, input int frac);
    int shift;
    int raw;
    int mag;
    shift = COEF_TABLE_FRAC - frac;      // bits to drop
    raw   = int'(coef_table[k][n]);      // sign extended entry
    mag   = (raw < 0) ? -raw : raw;      // work on the magnitude
    if (shift > 0)
      mag = (mag + (1 << (shift - 1))) >> shift;  // add half, truncate
    else
      mag = mag << (-shift);             // finer than table, pad zeros
    return (raw < 0) ? coef_t'(-mag) : coef_t'(mag);
  endfunction

  // drop frac fraction bits from an accumulator and clip to a sample
  function automatic sample_t round_sat(input acc_t acc, input int frac);
    acc_t biased;
    acc_t shifted;
    biased  = acc + (acc_t'(1) <<< (frac - 1));  // half an lsb
    shifted = biased >>> frac;                   // arithmetic, floors
    if (shifted > SAMPLE_MAX)
      return sample_t'(SAMPLE_MAX);              // clip high
    else if (shifted < SAMPLE_MIN)
      return sample_t'(SAMPLE_MIN);              // clip low
    else
      return sample_t'(shifted);
  endfunction

endpackage

/* source/dct_block_pkg.sv */
// block layout types and the pipeline word passed between the 2-d dct stages
package dct_block_pkg;

  // ****************************************
  // block geometry
  // ****************************************

  // one row of eight samples, element 0 in the low bits
  typedef dct_num_pkg::sample_t [dct_num_pkg::DCT_N-1:0] row_t;

  // eight rows, row 0 in the low bits
  // element (r, c) of a block b is b[r][c]
  typedef row_t [dct_num_pkg::DCT_N-1:0] block_t;

  // ****************************************
  // stage to stage word
  // ****************************************

  // the whole block moves at once with a single strobe
  // no ready, a stage must take the word every cycle
  typedef struct packed {
    logic   valid;  // block present this cycle
    block_t data;   // 64 samples, meaningful only with valid
  } blk_word_t;

endpackage

/* source/dct_row_1d.sv */
// combinational 8-point integer dct of one row, used per row inside dct_stage
`timescale 1ns/1ps

module dct_row_1d #(
  parameter int COEF_FRAC = 12  // fraction bits of the coefficients
) (
  input  dct_block_pkg::row_t x,  // spatial samples, x[0] first
  output dct_block_pkg::row_t y   // frequency terms, y[0] is dc
);
  import dct_num_pkg::*;

  localparam int HALF_N = DCT_N / 2;  // butterfly width

  sample_t xs       [DCT_N];   // signed view of the input row
  acc_t    bfly_sum [HALF_N];  // x[n] + x[7-n], feeds even terms
  acc_t    bfly_dif [HALF_N];  // x[n] - x[7-n], feeds odd terms

  // ****************************************
  // input butterfly
  // ****************************************
  for (genvar n = 0; n < DCT_N; n++) begin : g_in
    assign xs[n] = x[n];  // element select, keep it signed
  end

  // the even rows of the table mirror about the centre and the odd rows
  // mirror with a sign flip, so half the products are enough
  for (genvar n = 0; n < HALF_N; n++) begin : g_bfly
    assign bfly_sum[n] = acc_t'(xs[n]) + acc_t'(xs[DCT_N-1-n]);  // 17 bits used
    assign bfly_dif[n] = acc_t'(xs[n]) - acc_t'(xs[DCT_N-1-n]);
  end

  // ****************************************
  // multiply and accumulate per output term
  // ****************************************
  for (genvar k = 0; k < DCT_N; k++) begin : g_term
    acc_t tap [HALF_N];  // product per butterfly pair
    acc_t sum;           // full precision term

    for (genvar n = 0; n < HALF_N; n++) begin : g_tap
      localparam coef_t C = scaled_coef(k, n, COEF_FRAC);  // folded at elaboration

      if (k % 2 == 0) begin : g_even
        assign tap[n] = bfly_sum[n] * acc_t'(C);  // symmetric term
      end
      else begin : g_odd
        assign tap[n] = bfly_dif[n] * acc_t'(C);  // antisymmetric term
      end
    end

    always_comb
    begin
      sum = '0;
      for (int n = 0; n < HALF_N; n++)
        sum = sum + tap[n];  // fits in 32 bits for any 16-bit row
    end

    // back to sample scale, clipped
    assign y[k] = round_sat(sum, COEF_FRAC);
  end

endmodule

/* source/dct_stage.sv */
// registered pipeline stage that runs the 1-d dct over all eight rows of a block
`timescale 1ns/1ps

module dct_stage #(
  parameter int COEF_FRAC = 12  // passed on to every row engine
) (
  input  logic                     clk,
  input  logic                     rst_n,     // sync, active low
  input  dct_block_pkg::blk_word_t in_word,   // block from upstream
  output dct_block_pkg::blk_word_t out_word   // transformed block, one cycle later
);
  import dct_num_pkg::*;
  import dct_block_pkg::*;

  block_t row_res;  // combinational result of the eight row engines
  logic   valid_q;  // strobe register
  block_t data_q;   // payload register

  // ****************************************
  // one 1-d engine per row
  // ****************************************
  // used for the row pass as is, and for the column pass after a transpose
  for (genvar i = 0; i < DCT_N; i++) begin : g_row
    dct_row_1d #(
      .COEF_FRAC (COEF_FRAC)
    ) row_i (
      .x (in_word.data[i]),  // row i in
      .y (row_res[i])        // row i out
    );
  end

  // ****************************************
  // output register
  // ****************************************
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      valid_q <= 1'b0;           // nothing in flight after reset
    else
      valid_q <= in_word.valid;  // follows the data one stage down
  end

  // payload loads every cycle, its value only matters with valid_q
  always_ff @(posedge clk)
  begin
    data_q <= row_res;
  end

  assign out_word.valid = valid_q;
  assign out_word.data  = data_q;

endmodule

/* source/transpose_stage.sv */
// registered 8x8 transpose that turns rows into columns between the two dct passes
`timescale 1ns/1ps

module transpose_stage (
  input  logic                     clk,
  input  logic                     rst_n,     // sync, active low
  input  dct_block_pkg::blk_word_t in_word,   // block in row order
  output dct_block_pkg::blk_word_t out_word   // same block, (r,c) moved to (c,r)
);
  import dct_num_pkg::*;
  import dct_block_pkg::*;

  logic   valid_q;  // strobe register
  block_t data_q;   // transposed block

  // ****************************************
  // strobe
  // ****************************************
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else
      valid_q <= in_word.valid;  // one cycle, like the dct stages
  end

  // ****************************************
  // transpose
  // ****************************************
  // a pure rewiring of 64 samples into a register, the diagonal stays put
  // every element gets its own mirror, including (6,5) and (5,6)
  always_ff @(posedge clk)
  begin
    for (int r = 0; r < DCT_N; r++)
    begin
      for (int c = 0; c < DCT_N; c++)
        data_q[c][r] <= in_word.data[r][c];  // row r becomes column r
    end
  end

  assign out_word.valid = valid_q;
  assign out_word.data  = data_q;

endmodule

/* source/dct_2d_top.sv */
// top level of the 8x8 2-d dct, a four stage pipeline taking one block per cycle
`timescale 1ns/1ps

module dct_2d_top #(
  parameter int COEF_FRAC = 12  // coefficient fraction bits, 8 to 14
) (
  input  logic                  clk,
  input  logic                  rst_n,      // sync, active low
  input  logic                  in_valid,   // one strobe per block
  input  dct_block_pkg::block_t in_block,   // samples, valid with in_valid
  output logic                  out_valid,  // 4 cycles after in_valid
  output dct_block_pkg::block_t out_block   // Y[k][l] at row k, column l
);
  import dct_num_pkg::*;
  import dct_block_pkg::*;

  // stage boundaries, one register each
  blk_word_t in_word;     // packed input
  blk_word_t row_word;    // after row pass
  blk_word_t xpose_word;  // row pass result, transposed
  blk_word_t col_word;    // after column pass, still transposed
  blk_word_t out_word;    // natural order result

  // table precision bounds the useful range
  if (COEF_FRAC < 8 || COEF_FRAC > COEF_TABLE_FRAC) begin : g_frac_check
    $error("dct_2d_top: COEF_FRAC must be within 8..14");
  end

  assign in_word = '{valid: in_valid, data: in_block};

  // ****************************************
  // pipeline, Y = C * X * C^T
  // ****************************************
  dct_stage #(
    .COEF_FRAC (COEF_FRAC)
  ) row_pass_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_word  (in_word),
    .out_word (row_word)     // X * C^T, rows transformed
  );

  transpose_stage xpose_a_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_word  (row_word),
    .out_word (xpose_word)   // columns now lie along rows
  );

  dct_stage #(
    .COEF_FRAC (COEF_FRAC)
  ) col_pass_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_word  (xpose_word),
    .out_word (col_word)     // Y^T
  );

  transpose_stage xpose_b_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_word  (col_word),
    .out_word (out_word)     // back to Y
  );

  // unpack, no gating on the outputs
  assign out_valid = out_word.valid;
  assign out_block = out_word.data;

endmodule

/* bench/dct_2d_assertions.sv */
// strobe timing checks for the 2-d dct top, attached to every instance of it with bind
`timescale 1ns/1ps

module dct_2d_assertions (
  input logic clk,
  input logic rst_n,      // sync, active low
  input logic in_valid,   // block accepted at this edge
  input logic out_valid   // result presented at this edge
);

  localparam int LATENCY = 4;  // four registered stages

  // ****************************************
  // reset behaviour
  // ****************************************
  // the edge that sees rst_n low clears the stages, so out_valid is low
  // on the next edge and on the one after it
  a_quiet_in_reset : assert property (@(posedge clk)
    ($past(!rst_n, 1) || $past(!rst_n, 2)) |-> !out_valid)
    else $error("out_valid high during reset or in the cycle after it");

  // ****************************************
  // strobe pairing
  // ****************************************
  // every accepted block leaves exactly LATENCY edges later
  // unless a reset edge hit it while in flight
  a_in_gives_out : assert property (@(posedge clk)
    ($past(in_valid, LATENCY) && $past(rst_n, 4) && $past(rst_n, 3)
      && $past(rst_n, 2) && $past(rst_n, 1)) |-> out_valid)
    else $error("in_valid not followed by out_valid after %0d cycles", LATENCY);

  // no result appears without its input
  a_no_stray_out : assert property (@(posedge clk)
    out_valid |-> ($past(in_valid, LATENCY) && $past(rst_n, LATENCY)))
    else $error("out_valid without an in_valid %0d cycles earlier", LATENCY);

endmodule

// one checker per top level instance
bind dct_2d_top dct_2d_assertions assertions_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid)
);

/* bench/dct_2d_tb.sv */
// simulation top for the 2-d dct that drives blocks, models the transform and scores every output
`timescale 1ns/1ps

module dct_2d_tb;
  import dct_num_pkg::*;
  import dct_block_pkg::*;

  // ****************************************
  // run constants
  // ****************************************
  localparam int COEF_FRAC    = 12;
  localparam int CLK_HALF     = 20;   // ns for a 40 ns period
  localparam int RESET_CYCLES = 16;
  localparam int PIPE_DEPTH   = 4;    // in_valid edge to out_valid edge
  localparam int N_CONST      = 5;    // flat blocks
  localparam int N_RAND       = 200;  // back to back random blocks
  localparam int N_GAP        = 60;   // random blocks with idle gaps
  localparam int MAX_GAP      = 3;
  localparam int N_BOARD      = 2;    // full scale checkerboards
  localparam int N_PRE_RST    = 6;    // sent just before the mid-run reset
  localparam int N_POST_RST   = 10;
  localparam int RST_HOLD     = 4;    // cycles of the mid-run reset
  localparam int N_BLOCKS     = N_CONST + DCT_N * DCT_N + N_RAND + N_GAP + N_BOARD
                                + N_PRE_RST + N_POST_RST;
  // idle gaps, the mid-run reset and six drains add slots on top of the blocks
  localparam int N_SLOTS      = N_BLOCKS + N_GAP * MAX_GAP + RST_HOLD + 6 * (PIPE_DEPTH + 2);
  localparam longint WATCH_NS = longint'(N_SLOTS + 40 + RESET_CYCLES) * 2 * CLK_HALF;

  localparam int FLAT_VALS [N_CONST] = '{0, 100, -255, 32767, -32768};

  logic   clk;
  logic   rst_n;
  logic   in_valid;
  block_t in_block;
  logic   out_valid;
  block_t out_block;

  int     seed;            // $random state
  block_t stim_blk;        // block being sent
  int     gap;             // idle cycles after a block
  block_t exp_in;          // expected result moving with in_block
  block_t exp_q [$];       // expected results in input order
  int     due_q [$];       // edge at which each result is due
  block_t exp_blk;         // front of exp_q
  int     due_cyc;         // front of due_q
  int     cyc = 0;         // rising edges seen
  logic   rst_prev = 1'b1; // rst_n seen at the previous edge
  int     sent_count;      // input strobes issued
  int     out_count;       // outputs scored

  // ****************************************
  // clock and DUT
  // ****************************************
  initial clk = 1'b0;
  always #(CLK_HALF) clk = ~clk;

  dct_2d_top #(
    .COEF_FRAC (COEF_FRAC)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_block  (in_block),
    .out_valid (out_valid),
    .out_block (out_block)
  );

  // ****************************************
  // reference model and stimulus blocks
  // ****************************************
  // straight eight-product sums per term over rows first and then columns
  function automatic block_t dct2_ref(input block_t x);
    block_t  tmp;
    block_t  y;
    acc_t    acc;
    sample_t s;
    for (int r = 0; r < DCT_N; r++)
      for (int k = 0; k < DCT_N; k++)
      begin
        acc = '0;
        for (int n = 0; n < DCT_N; n++)
        begin
          s   = x[r][n];  // signed copy
          acc = acc + acc_t'(s) * acc_t'(scaled_coef(k, n, COEF_FRAC));
        end
        tmp[r][k] = round_sat(acc, COEF_FRAC);  // row r term k
      end
    for (int k = 0; k < DCT_N; k++)
      for (int l = 0; l < DCT_N; l++)
      begin
        acc = '0;
        for (int r = 0; r < DCT_N; r++)
        begin
          s   = tmp[r][l];  // column l of the row result
          acc = acc + acc_t'(s) * acc_t'(scaled_coef(k, r, COEF_FRAC));
        end
        y[k][l] = round_sat(acc, COEF_FRAC);
      end
    return y;
  endfunction

  // a flat block of v leaves only the dc term at (0,0) after one rounding per pass
  function automatic block_t dc_block(input sample_t v);
    block_t  b;
    acc_t    c00;
    sample_t row_dc;
    c00     = acc_t'(scaled_coef(0, 0, COEF_FRAC));
    row_dc  = round_sat(acc_t'(DCT_N) * acc_t'(v) * c00, COEF_FRAC);  // same in every row
    b       = '0;
    b[0][0] = round_sat(acc_t'(DCT_N) * acc_t'(row_dc) * c00, COEF_FRAC);
    return b;
  endfunction

  function automatic block_t flat_block(input sample_t v);
    block_t b;
    for (int r = 0; r < DCT_N; r++)
      for (int c = 0; c < DCT_N; c++)
        b[r][c] = v;
    return b;
  endfunction

  function automatic block_t impulse_block(input int r, input int c, input sample_t v);
    block_t b;
    b       = '0;
    b[r][c] = v;
    return b;
  endfunction

  // samples in the 9-bit signed range
  function automatic block_t rand_block();
    block_t            b;
    logic signed [8:0] v9;
    for (int r = 0; r < DCT_N; r++)
      for (int c = 0; c < DCT_N; c++)
      begin
        v9      = 9'($random(seed));
        b[r][c] = sample_t'(v9);  // sign extended
      end
    return b;
  endfunction

  // +/-32767 alternating drives the high terms into saturation
  function automatic block_t board_block(input logic invert);
    block_t b;
    logic   odd;
    for (int r = 0; r < DCT_N; r++)
      for (int c = 0; c < DCT_N; c++)
      begin
        odd     = ((r + c) % 2) != 0;
        b[r][c] = (odd ^ invert) ? sample_t'(-32767) : sample_t'(32767);
      end
    return b;
  endfunction

  // ****************************************
  // checks
  // ****************************************
  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_block(input block_t act, input block_t exp);
    logic    found;
    int      bad_r;
    int      bad_c;
    sample_t a;
    sample_t e;
    found = 1'b0;
    bad_r = 0;
    bad_c = 0;
    for (int r = 0; r < DCT_N; r++)
      for (int c = 0; c < DCT_N; c++)
        if (!found && act[r][c] !== exp[r][c])
        begin
          found = 1'b1;  // report the first bad element only
          bad_r = r;
          bad_c = c;
        end
    if (found)
    begin
      a = act[bad_r][bad_c];
      e = exp[bad_r][bad_c];
      $display("Error: %0d ns: out_block row %0d column %0d expected %0d, got %0d",
               $time, bad_r, bad_c, e, a);
      abort_run();
    end
  endtask

  task automatic check_count(input int act, input int exp, input string what);
    if (act != exp)
    begin
      $display("Error: %0d ns: %s expected %0d, got %0d", $time, what, exp, act);
      abort_run();
    end
  endtask

  // scoreboard sampling at the rising edge what the DUT samples
  always @(posedge clk)
  begin
    cyc = cyc + 1;
    if (!rst_n)
    begin
      // only the first edge of a reset may still show a result
      if (!rst_prev && out_valid)
      begin
        $display("Error: %0d ns: out_valid high while rst_n is held low", $time);
        abort_run();
      end
      exp_q.delete();  // blocks in flight are lost
      due_q.delete();
    end
    else
    begin
      if (out_valid)
      begin
        if (exp_q.size() == 0)
        begin
          $display("%0d ns: output strobe without a pending input", $time);
          abort_run();
        end
        else
        begin
          exp_blk = exp_q.pop_front();
          due_cyc = due_q.pop_front();
          check_count(cyc, due_cyc, "output edge");  // fixed latency
          check_block(out_block, exp_blk);
          out_count = out_count + 1;
        end
      end
      else if (due_q.size() != 0 && due_q[0] <= cyc)
      begin
        $display("%0d ns: in_valid strobe got no out_valid %0d cycles later",
                 $time, PIPE_DEPTH);
        abort_run();
      end
      if (in_valid)
      begin
        exp_q.push_back(exp_in);
        due_q.push_back(cyc + PIPE_DEPTH);
      end
    end
    rst_prev = rst_n;
  end

  // ****************************************
  // stimulus tasks
  // ****************************************
  task automatic send_block(input block_t blk, input block_t exp);
    @(posedge clk);
    in_valid   <= 1'b1;
    in_block   <= blk;
    exp_in     <= exp;
    sent_count = sent_count + 1;
  endtask

  task automatic send_idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // wait until every pending result has been scored
  task automatic drain();
    send_idle(1);
    @(negedge clk);
    while (exp_q.size() != 0)
      @(negedge clk);
  endtask

  task automatic pulse_reset(input int cycles);
    @(posedge clk);
    in_valid <= 1'b0;
    rst_n    <= 1'b0;
    repeat (cycles) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // ****************************************
  // test sequence
  // ****************************************
  initial
  begin
    seed       = 32'ha639;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_block   = '0;
    exp_in     = '0;
    sent_count = 0;
    out_count  = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < N_CONST; i++)  // flat blocks give dc only
      send_block(flat_block(sample_t'(FLAT_VALS[i])), dc_block(sample_t'(FLAT_VALS[i])));
    drain();

    for (int r = 0; r < DCT_N; r++)  // one impulse per element position
      for (int c = 0; c < DCT_N; c++)
      begin
        stim_blk = impulse_block(r, c, ((r + c) % 2 == 0) ? sample_t'(1000) : sample_t'(-777));
        send_block(stim_blk, dct2_ref(stim_blk));
      end
    drain();

    for (int i = 0; i < N_RAND; i++)  // four blocks in flight
    begin
      stim_blk = rand_block();
      send_block(stim_blk, dct2_ref(stim_blk));
    end
    drain();

    for (int i = 0; i < N_GAP; i++)
    begin
      stim_blk = rand_block();
      gap      = $unsigned($random(seed)) % (MAX_GAP + 1);
      send_block(stim_blk, dct2_ref(stim_blk));
      send_idle(gap);
    end
    drain();

    for (int i = 0; i < N_BOARD; i++)  // saturating inputs
    begin
      stim_blk = board_block(i[0]);
      send_block(stim_blk, dct2_ref(stim_blk));
    end
    drain();

    for (int i = 0; i < N_PRE_RST; i++)
    begin
      stim_blk = rand_block();
      send_block(stim_blk, dct2_ref(stim_blk));
    end
    pulse_reset(RST_HOLD);  // the last PIPE_DEPTH blocks are dropped
    for (int i = 0; i < N_POST_RST; i++)
    begin
      stim_blk = rand_block();
      send_block(stim_blk, dct2_ref(stim_blk));
    end
    drain();
    check_count(out_count, sent_count - PIPE_DEPTH, "number of outputs");

    if (exp_q.size() == 0)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
    begin
      $display("results still pending at the end of the run");
      abort_run();
    end
  end

  // watchdog
  initial
  begin
    #(WATCH_NS);
    $display("timeout: outputs missing");
    abort_run();
  end

endmodule

/* sim.f */
source/dct_num_pkg.sv
source/dct_block_pkg.sv
source/dct_row_1d.sv
source/dct_stage.sv
source/transpose_stage.sv
source/dct_2d_top.sv
bench/dct_2d_assertions.sv
bench/dct_2d_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the 2-D DCT testbench with Verilator, run it, and scan the log for the fail message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=dct_2d_sim

verilator --binary --timing --assert -Wno-fatal --top-module dct_2d_tb \
  -f sim.f --Mdir "$BUILD_DIR" -o "$SIM_BIN" > "$BUILD_LOG" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "build failed with status $build_status, see $BUILD_LOG"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$SIM_LOG" 2>&1
run_status=$?

grep -q "FAIL: see errors above" "$SIM_LOG"
grep_status=$?
if [ "$grep_status" -eq 0 ]; then
  echo "simulation failed, see $SIM_LOG"
  exit 1
fi
if [ "$grep_status" -ne 1 ]; then
  echo "could not read $SIM_LOG"
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "simulator exited with status $run_status, see $SIM_LOG"
  exit 1
fi

echo "simulation passed"
exit 0
